// File: Bender.yml
package:
  name: phy_test

export_include_dirs:
  - .

sources:
  - phy_test_pkg.sv
  - phy_test_if.sv
  - phy_test_ram.sv
  - phy_test_pattern_gen.sv
  - phy_test_rx_checker.sv
  - phy_test_rx_log_reg.sv
  - phy_test_ctrl.sv
  - phy_test_top.sv
  - target: test
    files:
      - tb_phy_test.sv

// File: phy_test_config.svh
// ==========================================================
// PHY self-test configuration macros
//   Word and log index widths, log depth
//   Global and log window register byte offsets
//   Log control field position and unmapped read value
// ==========================================================
`ifndef PHY_TEST_CONFIG_SVH
`define PHY_TEST_CONFIG_SVH

// Word and index sizes
`define PHY_TEST_DATA_WIDTH           32
`define PHY_TEST_LOG_ADDR_WIDTH       9
`define PHY_TEST_LOG_DEPTH            512
`define PHY_TEST_REG_ADDR_WIDTH       6

// Global registers
`define PHY_TEST_CTRL                 6'h00
`define PHY_TEST_SEED                 6'h04
`define PHY_TEST_PKT_COUNT            6'h08
`define PHY_TEST_ERR_COUNT            6'h0c

// Log window, 0x10 to 0x1F
`define PHY_TEST_RX_LOG_STATUS        6'h10
`define PHY_TEST_RX_LOG_EXP_DATA      6'h14
`define PHY_TEST_RX_LOG_RX_DATA       6'h18
`define PHY_TEST_RX_LOG_CTRL          6'h1c

`define PHY_TEST_RX_LOG_CTRL_RESET_POS 0
`define PHY_TEST_BAD_ADDR_DATA        32'hdead_beef

`endif

// File: phy_test_ctrl.sv
// ==========================================================
// Register bus control
//   Address decode and log window routing
//   CTRL, SEED and counter registers
//   Restart pulse generation
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "phy_test_config.svh"

module phy_test_ctrl (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    reg_req,
   input  logic                    reg_rd_wr_l,
   input  phy_test_pkg::reg_addr_t reg_addr,
   input  phy_test_pkg::phy_word_t reg_wr_data,
   output logic                    reg_ack,
   output phy_test_pkg::phy_word_t reg_rd_data,
   reg_bus_if.master               log_bus,
   input  phy_test_pkg::phy_word_t pkt_count,
   input  phy_test_pkg::phy_word_t err_count,
   output phy_test_pkg::phy_word_t seed,
   output logic                    restart
);
   import phy_test_pkg::*;

   logic      in_window;
   logic      acked;
   logic      new_req;
   logic      glob_ack;
   phy_word_t glob_rd_data;

   // Log window is 0x10 to 0x1F
   assign in_window = (reg_addr & 6'h30) == `PHY_TEST_RX_LOG_STATUS;
   assign new_req   = reg_req && !in_window && !acked;

   assign log_bus.req     = reg_req && in_window;
   assign log_bus.rd_wr_l = reg_rd_wr_l;
   assign log_bus.addr    = reg_addr[3:0];
   assign log_bus.wr_data = reg_wr_data;

   // Log answers pass straight through
   assign reg_ack     = log_bus.ack || glob_ack;
   assign reg_rd_data = log_bus.ack ? log_bus.rd_data : glob_rd_data;

   always_ff @(posedge clk) begin
      if (reset) begin
         acked    <= 1'b0;
         glob_ack <= 1'b0;
         restart  <= 1'b0;
         seed     <= phy_word_t'(1);
      end
      else begin
         acked    <= reg_req;
         glob_ack <= new_req;
         // CTRL bit 0 requests a restart
         restart  <= new_req && !reg_rd_wr_l && (reg_addr == `PHY_TEST_CTRL) &&
                     reg_wr_data[0];
         if (new_req && !reg_rd_wr_l && reg_addr == `PHY_TEST_SEED) begin
            seed <= reg_wr_data;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (new_req) begin
         case (reg_addr)
            `PHY_TEST_CTRL:      glob_rd_data <= '0;
            `PHY_TEST_SEED:      glob_rd_data <= seed;
            `PHY_TEST_PKT_COUNT: glob_rd_data <= pkt_count;
            `PHY_TEST_ERR_COUNT: glob_rd_data <= err_count;
            default:             glob_rd_data <= `PHY_TEST_BAD_ADDR_DATA;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: phy_test_if.sv
// ==========================================================
// PHY self-test interfaces
//   reg_bus_if  level request, one-cycle ack register bus
//   log_wr_if   word pair stream from checker into the log
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "phy_test_config.svh"

interface reg_bus_if;
   import phy_test_pkg::*;

   logic      req;
   // 1 = read, 0 = write
   logic      rd_wr_l;
   // Low 4 bits of the byte address
   logic [3:0] addr;
   phy_word_t wr_data;
   logic      ack;
   phy_word_t rd_data;

   modport master (output req, rd_wr_l, addr, wr_data, input ack, rd_data);
   modport slave  (input req, rd_wr_l, addr, wr_data, output ack, rd_data);
endinterface

interface log_wr_if;
   import phy_test_pkg::*;

   phy_word_t rx_data;
   phy_word_t exp_data;
   log_addr_t addr;
   logic      wr;
   // Last word of the packet
   logic      done;
   // Packet had a mismatch, set together with done
   logic      hold;

   modport source (output rx_data, exp_data, addr, wr, done, hold);
   modport sink   (input rx_data, exp_data, addr, wr, done, hold);
endinterface

`default_nettype wire

// File: phy_test_pattern_gen.sv
// ==========================================================
// Expected word generator
//   32-bit LFSR, one step per accepted word
//   Reloads the seed at packet end, reset and restart
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "phy_test_config.svh"

module phy_test_pattern_gen (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    restart,
   input  logic                    step,
   input  logic                    last,
   input  phy_test_pkg::phy_word_t seed,
   output phy_test_pkg::phy_word_t exp_word
);
   import phy_test_pkg::*;

   phy_word_t state;
   logic      feedback;

   assign feedback = ^(state & LFSR_TAPS);
   assign exp_word = state;

   // Word k of every packet is the seed advanced k steps
   always_ff @(posedge clk) begin
      if (reset || restart) begin
         state <= seed;
      end
      else if (step) begin
         if (last) begin
            state <= seed;
         end
         else begin
            state <= {state[`PHY_TEST_DATA_WIDTH-2:0], feedback};
         end
      end
   end

endmodule

`default_nettype wire

// File: phy_test_pkg.sv
// ==========================================================
// PHY self-test shared types
//   Data word, log index and register address types
//   Pattern LFSR tap mask
// ==========================================================
`default_nettype none

`include "phy_test_config.svh"

package phy_test_pkg;

   // Register and data word
   typedef logic [`PHY_TEST_DATA_WIDTH-1:0] phy_word_t;

   // Index into the capture log
   typedef logic [`PHY_TEST_LOG_ADDR_WIDTH-1:0] log_addr_t;

   // Byte address on the top level register bus
   typedef logic [`PHY_TEST_REG_ADDR_WIDTH-1:0] reg_addr_t;

   // Pattern LFSR taps at bits 31, 21, 1 and 0.
   // New bit 0 is the XOR of the state bits under this mask
   localparam phy_word_t LFSR_TAPS = 32'h8020_0003;

endpackage

`default_nettype wire

// File: phy_test_ram.sv
// ==========================================================
// Simple dual-port RAM for the capture log
//   Synchronous write port, registered read port
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "phy_test_config.svh"

module phy_test_ram (
   input  logic                    clk,
   input  logic                    wr_en,
   input  phy_test_pkg::log_addr_t wr_addr,
   input  phy_test_pkg::log_addr_t rd_addr,
   input  phy_test_pkg::phy_word_t wr_data,
   output phy_test_pkg::phy_word_t rd_data
);
   import phy_test_pkg::*;

   phy_word_t mem [`PHY_TEST_LOG_DEPTH];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Read data follows the address of the previous edge
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// File: phy_test_rx_checker.sv
// ==========================================================
// Receive checker
//   Compares each received word with the expected word
//   Streams word pairs to the log with done and hold
//   Packet and errored packet counters
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "phy_test_config.svh"

module phy_test_rx_checker (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    restart,
   input  logic                    rx_valid,
   input  logic                    rx_last,
   input  phy_test_pkg::phy_word_t rx_data,
   input  phy_test_pkg::phy_word_t exp_word,
   output logic                    step,
   output logic                    last,
   log_wr_if.source                log,
   output phy_test_pkg::phy_word_t pkt_count,
   output phy_test_pkg::phy_word_t err_count
);
   import phy_test_pkg::*;

   log_addr_t word_idx;
   logic      pkt_err;
   logic      mismatch;
   logic      pkt_bad;

   assign mismatch = rx_data != exp_word;
   // Any word of the packet so far, this one included
   assign pkt_bad  = pkt_err || mismatch;

   // Generator advances on the same edge that samples the word
   assign step = rx_valid;
   assign last = rx_valid && rx_last;

   // Word pair payload for the log
   always_ff @(posedge clk) begin
      if (rx_valid) begin
         log.rx_data  <= rx_data;
         log.exp_data <= exp_word;
         log.addr     <= word_idx;
      end
   end

   always_ff @(posedge clk) begin
      if (reset || restart) begin
         word_idx  <= '0;
         pkt_err   <= 1'b0;
         log.wr    <= 1'b0;
         log.done  <= 1'b0;
         log.hold  <= 1'b0;
         pkt_count <= '0;
         err_count <= '0;
      end
      else begin
         log.wr   <= rx_valid;
         log.done <= last;
         log.hold <= last && pkt_bad;

         if (rx_valid) begin
            word_idx <= rx_last ? '0 : word_idx + log_addr_t'(1);
            pkt_err  <= !rx_last && pkt_bad;
         end

         // Counters move on the edge after the last word
         if (log.done) begin
            pkt_count <= pkt_count + phy_word_t'(1);
            if (log.hold) begin
               err_count <= err_count + phy_word_t'(1);
            end
         end
      end
   end

   a_last_with_valid: assert property (
      @(posedge clk) disable iff (reset) rx_last |-> rx_valid);

endmodule

`default_nettype wire

// File: phy_test_rx_log_reg.sv
// ==========================================================
// Receive log for one source
//   Captures the first errored packet and locks
//   Status, data read-out and log reset registers
//   Expected and received word RAMs
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "phy_test_config.svh"

module phy_test_rx_log_reg (
   input  logic     clk,
   input  logic     reset,
   input  logic     restart,
   reg_bus_if.slave bus,
   log_wr_if.sink   log
);
   import phy_test_pkg::*;

   // Offsets inside the log window
   localparam logic [3:0] OFS_STATUS   = 4'(`PHY_TEST_RX_LOG_STATUS);
   localparam logic [3:0] OFS_EXP_DATA = 4'(`PHY_TEST_RX_LOG_EXP_DATA);
   localparam logic [3:0] OFS_RX_DATA  = 4'(`PHY_TEST_RX_LOG_RX_DATA);
   localparam logic [3:0] OFS_CTRL     = 4'(`PHY_TEST_RX_LOG_CTRL);

   log_addr_t depth;
   logic      full;
   logic      lock;
   log_addr_t exp_ptr;
   log_addr_t rx_ptr;
   phy_word_t exp_rd_data;
   phy_word_t rx_rd_data;
   logic      acked;
   logic      new_req;
   logic      rd_req;
   logic      reset_log;
   logic      ram_we;
   logic      exp_avail;
   logic      rx_avail;

   assign new_req   = bus.req && !acked;
   assign rd_req    = new_req && bus.rd_wr_l;
   assign exp_avail = full && (exp_ptr != depth);
   assign rx_avail  = full && (rx_ptr != depth);
   assign ram_we    = log.wr && !lock;

   // ==========================================================
   // Register access, one ack per request
   // ==========================================================
   always_ff @(posedge clk) begin
      if (reset) begin
         acked     <= 1'b0;
         bus.ack   <= 1'b0;
         reset_log <= 1'b0;
      end
      else begin
         acked     <= bus.req;
         bus.ack   <= new_req;
         reset_log <= new_req && !bus.rd_wr_l && (bus.addr == OFS_CTRL) &&
                      bus.wr_data[`PHY_TEST_RX_LOG_CTRL_RESET_POS];
      end
   end

   always_ff @(posedge clk) begin
      if (new_req) begin
         case (bus.addr)
            OFS_STATUS:   bus.rd_data <= {15'b0, depth, 7'b0, full};
            OFS_EXP_DATA: bus.rd_data <= exp_avail ? exp_rd_data : '0;
            OFS_RX_DATA:  bus.rd_data <= rx_avail ? rx_rd_data : '0;
            OFS_CTRL:     bus.rd_data <= '0;
            default:      bus.rd_data <= `PHY_TEST_BAD_ADDR_DATA;
         endcase
      end
   end

   // ==========================================================
   // Capture, lock and read pointers
   // ==========================================================
   always_ff @(posedge clk) begin
      if (reset || restart) begin
         exp_ptr <= '0;
         rx_ptr  <= '0;
         depth   <= '0;
         full    <= 1'b0;
         lock    <= 1'b0;
      end
      else begin
         if (rd_req && bus.addr == OFS_EXP_DATA && exp_avail) begin
            exp_ptr <= exp_ptr + log_addr_t'(1);
         end
         else if (rd_req && bus.addr == OFS_RX_DATA && rx_avail) begin
            rx_ptr <= rx_ptr + log_addr_t'(1);
         end
         else if (reset_log) begin
            exp_ptr <= '0;
            rx_ptr  <= '0;
         end

         if (!lock && log.hold) begin
            full  <= 1'b1;
            depth <= log.addr + log_addr_t'(1);
            lock  <= 1'b1;
         end
         else if (reset_log) begin
            full  <= 1'b0;
            depth <= '0;
            lock  <= lock && !log.done;
         end
         else if (lock && !full) begin
            // Wait out the packet after a log reset
            lock <= !log.done;
         end
      end
   end

   phy_test_ram exp_ram (
      .clk     (clk),
      .wr_en   (ram_we),
      .wr_addr (log.addr),
      .rd_addr (exp_ptr),
      .wr_data (log.exp_data),
      .rd_data (exp_rd_data)
   );

   phy_test_ram rx_ram (
      .clk     (clk),
      .wr_en   (ram_we),
      .wr_addr (log.addr),
      .rd_addr (rx_ptr),
      .wr_data (log.rx_data),
      .rd_data (rx_rd_data)
   );

   // Captured packet stays write protected until a log reset
   a_full_locked: assert property (
      @(posedge clk) disable iff (reset || restart) full |-> lock);

   // Master keeps req up until the ack arrives
   a_req_held: assert property (
      @(posedge clk) disable iff (reset) bus.req && !bus.ack |=> bus.req || bus.ack);

endmodule

`default_nettype wire

// File: phy_test_top.sv
// ==========================================================
// PHY self-test receive path top level
//   Register control, pattern generator, checker and log
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "phy_test_config.svh"

module phy_test_top (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    rx_valid,
   input  phy_test_pkg::phy_word_t rx_data,
   input  logic                    rx_last,
   input  logic                    reg_req,
   input  logic                    reg_rd_wr_l,
   input  phy_test_pkg::reg_addr_t reg_addr,
   input  phy_test_pkg::phy_word_t reg_wr_data,
   output logic                    reg_ack,
   output phy_test_pkg::phy_word_t reg_rd_data
);
   import phy_test_pkg::*;

   phy_word_t seed;
   phy_word_t exp_word;
   phy_word_t pkt_count;
   phy_word_t err_count;
   logic      restart;
   logic      step;
   logic      last;

   reg_bus_if log_bus ();
   log_wr_if  log_wr ();

   phy_test_ctrl ctrl_inst (
      .clk         (clk),
      .reset       (reset),
      .reg_req     (reg_req),
      .reg_rd_wr_l (reg_rd_wr_l),
      .reg_addr    (reg_addr),
      .reg_wr_data (reg_wr_data),
      .reg_ack     (reg_ack),
      .reg_rd_data (reg_rd_data),
      .log_bus     (log_bus.master),
      .pkt_count   (pkt_count),
      .err_count   (err_count),
      .seed        (seed),
      .restart     (restart)
   );

   phy_test_pattern_gen pattern_gen_inst (
      .clk      (clk),
      .reset    (reset),
      .restart  (restart),
      .step     (step),
      .last     (last),
      .seed     (seed),
      .exp_word (exp_word)
   );

   phy_test_rx_checker rx_checker_inst (
      .clk       (clk),
      .reset     (reset),
      .restart   (restart),
      .rx_valid  (rx_valid),
      .rx_last   (rx_last),
      .rx_data   (rx_data),
      .exp_word  (exp_word),
      .step      (step),
      .last      (last),
      .log       (log_wr.source),
      .pkt_count (pkt_count),
      .err_count (err_count)
   );

   phy_test_rx_log_reg rx_log_reg_inst (
      .clk     (clk),
      .reset   (reset),
      .restart (restart),
      .bus     (log_bus.slave),
      .log     (log_wr.sink)
   );

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
phy_test_pkg.sv
phy_test_if.sv
phy_test_ram.sv
phy_test_pattern_gen.sv
phy_test_rx_checker.sv
phy_test_rx_log_reg.sv
phy_test_ctrl.sv
phy_test_top.sv
tb_phy_test.sv

// File: tb_phy_test.sv
// ==========================================================
// Testbench for the PHY self-test receive path
//   Reference pattern model and random source
//   Register access and packet tasks
//   Directed tests for counters, log capture and restart
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "phy_test_config.svh"

module tb_phy_test;

   localparam int CLK_PERIOD     = 100;
   localparam int DRIVE_DELAY    = 10;
   localparam int ACK_LIMIT      = 16;
   localparam int TIMEOUT_CYCLES = 20000;

   logic        clk;
   logic        reset;
   logic        rx_valid;
   logic [31:0] rx_data;
   logic        rx_last;
   logic        reg_req;
   logic        reg_rd_wr_l;
   logic [5:0]  reg_addr;
   logic [31:0] reg_wr_data;
   logic        reg_ack;
   logic [31:0] reg_rd_data;

   int          cycle_count = 0;
   int          checks = 0;
   int          errors = 0;
   int          test_errors = 0;
   logic [31:0] rand_state = 32'h078f_85ff;
   logic [31:0] cur_seed = 32'h0000_0001;
   logic [31:0] exp_q [$];
   logic [31:0] sent_q [$];

   phy_test_top phy_test_top_inst (
      .clk         (clk),
      .reset       (reset),
      .rx_valid    (rx_valid),
      .rx_data     (rx_data),
      .rx_last     (rx_last),
      .reg_req     (reg_req),
      .reg_rd_wr_l (reg_rd_wr_l),
      .reg_addr    (reg_addr),
      .reg_wr_data (reg_wr_data),
      .reg_ack     (reg_ack),
      .reg_rd_data (reg_rd_data)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Test FAILED");
         $finish;
      end
   end

   // ==========================================================
   // Reference models
   // ==========================================================

   // One pattern step, new bit 0 from taps 31, 21, 1 and 0
   function automatic logic [31:0] pattern_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // Fibonacci LFSR, one step per bit taken
   function automatic int next_random(input int nbits);
      int   i;
      int   val;
      logic fb;
      val = 0;
      for (i = 0; i < nbits; i++) begin
         fb = rand_state[31] ^ rand_state[21] ^ rand_state[1] ^ rand_state[0];
         rand_state = {rand_state[30:0], fb};
         val = (val << 1) | int'(rand_state[0]);
      end
      return val;
   endfunction

   // Depth in bits 16 to 8, full in bit 0
   function automatic logic [31:0] status_word(input int depth, input bit full);
      return (32'(depth) << 8) | 32'(full);
   endfunction

   // ==========================================================
   // Checks and register access
   // ==========================================================
   task automatic check_equal(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
      checks++;
      assert (got === expected) else begin
         errors++;
         test_errors++;
         $display("error: %0t ns: %s read 0x%h, expected 0x%h", $time, what, got, expected);
      end
   endtask

   task automatic finish_test(input string name);
      $display("test %s finished with %0d errors", name, test_errors);
      test_errors = 0;
   endtask

   // Called and returns 10 ns after a rising edge
   task automatic reg_access(input bit rd, input logic [5:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      int waited;
      bit seen;
      reg_req     = 1'b1;
      reg_rd_wr_l = rd;
      reg_addr    = addr;
      reg_wr_data = wdata;
      waited      = 0;
      seen        = 1'b0;
      rdata       = '0;
      while (!seen && waited < ACK_LIMIT) begin
         @(posedge clk);
         #DRIVE_DELAY;
         waited++;
         if (reg_ack) begin
            seen  = 1'b1;
            rdata = reg_rd_data;
         end
      end
      reg_req = 1'b0;
      checks++;
      assert (seen) else begin
         errors++;
         test_errors++;
         $display("no acknowledge for register access at 0x%h within %0d cycles",
                  addr, ACK_LIMIT);
      end
      if (seen) begin
         check_equal("ack latency", 32'(waited), 32'd1);
         @(posedge clk);
         #DRIVE_DELAY;
         checks++;
         assert (!reg_ack) else begin
            errors++;
            test_errors++;
            $display("register access at 0x%h gave a second acknowledge pulse", addr);
         end
      end
   endtask

   task automatic reg_write(input logic [5:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      reg_access(1'b0, addr, data, unused);
   endtask

   task automatic reg_read(input logic [5:0] addr, output logic [31:0] data);
      reg_access(1'b1, addr, '0, data);
   endtask

   task automatic read_expect(input string what, input logic [5:0] addr,
                              input logic [31:0] expected);
      logic [31:0] data;
      reg_read(addr, data);
      check_equal(what, data, expected);
   endtask

   // ==========================================================
   // Packet stimulus and log read-out
   // ==========================================================

   // bad_idx below 0 sends a clean packet
   task automatic send_packet(input int len, input int bad_idx, input bit with_last);
      int          k;
      logic [31:0] state;
      logic [31:0] word;
      state = cur_seed;
      exp_q.delete();
      sent_q.delete();
      for (k = 0; k < len; k++) begin
         word = state;
         if (k == bad_idx) begin
            word[0] = ~word[0];
         end
         exp_q.push_back(state);
         sent_q.push_back(word);
         rx_valid = 1'b1;
         rx_data  = word;
         rx_last  = with_last && (k == len - 1);
         @(posedge clk);
         #DRIVE_DELAY;
         state = pattern_next(state);
      end
      rx_valid = 1'b0;
      rx_last  = 1'b0;
      rx_data  = '0;
      // Log write and counters land one edge after the last word
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic check_log_readout(input int len);
      int k;
      for (k = 0; k < len; k++) begin
         read_expect("log expected word", `PHY_TEST_RX_LOG_EXP_DATA, exp_q[k]);
      end
      read_expect("log expected past depth", `PHY_TEST_RX_LOG_EXP_DATA, 32'h0);
      for (k = 0; k < len; k++) begin
         read_expect("log received word", `PHY_TEST_RX_LOG_RX_DATA, sent_q[k]);
      end
      read_expect("log received past depth", `PHY_TEST_RX_LOG_RX_DATA, 32'h0);
   endtask

   task automatic restart_with_seed(input logic [31:0] seed);
      reg_write(`PHY_TEST_SEED, seed);
      cur_seed = seed;
      reg_write(`PHY_TEST_CTRL, 32'h1);
   endtask

   // ==========================================================
   // Directed tests
   // ==========================================================
   task automatic test_register_access();
      logic [31:0] value;
      value = 32'(next_random(32));
      reg_write(`PHY_TEST_SEED, value);
      read_expect("seed", `PHY_TEST_SEED, value);
      read_expect("ctrl", `PHY_TEST_CTRL, 32'h0);
      read_expect("unmapped", 6'h3c, 32'hdead_beef);
      finish_test("register_access");
   endtask

   task automatic test_clean_packets();
      int n;
      restart_with_seed(32'(next_random(32)) | 32'h1);
      for (n = 0; n < 3; n++) begin
         send_packet(4 + next_random(3), -1, 1'b1);
      end
      read_expect("packet count", `PHY_TEST_PKT_COUNT, 32'd3);
      read_expect("error count", `PHY_TEST_ERR_COUNT, 32'd0);
      read_expect("log status", `PHY_TEST_RX_LOG_STATUS, 32'h0);
      finish_test("clean_packets");
   endtask

   task automatic test_error_capture(output int cap_len);
      logic [31:0] err_before;
      int          len;
      len = 8 + next_random(3);
      reg_read(`PHY_TEST_ERR_COUNT, err_before);
      send_packet(len, next_random(4) % len, 1'b1);
      read_expect("error count", `PHY_TEST_ERR_COUNT, err_before + 32'd1);
      read_expect("log status", `PHY_TEST_RX_LOG_STATUS, status_word(len, 1'b1));
      check_log_readout(len);
      cap_len = len;
      finish_test("error_capture");
   endtask

   task automatic test_lock_hold(input int cap_len);
      logic [31:0] err_before;
      reg_read(`PHY_TEST_ERR_COUNT, err_before);
      send_packet(cap_len + 3, 0, 1'b1);
      read_expect("error count", `PHY_TEST_ERR_COUNT, err_before + 32'd1);
      read_expect("locked status", `PHY_TEST_RX_LOG_STATUS, status_word(cap_len, 1'b1));
      read_expect("locked expected", `PHY_TEST_RX_LOG_EXP_DATA, 32'h0);
      read_expect("locked received", `PHY_TEST_RX_LOG_RX_DATA, 32'h0);
      reg_write(`PHY_TEST_RX_LOG_CTRL, 32'h1 << `PHY_TEST_RX_LOG_CTRL_RESET_POS);
      read_expect("status after log reset", `PHY_TEST_RX_LOG_STATUS, 32'h0);
      read_expect("expected after log reset", `PHY_TEST_RX_LOG_EXP_DATA, 32'h0);
      read_expect("received after log reset", `PHY_TEST_RX_LOG_RX_DATA, 32'h0);
      finish_test("lock_hold");
   endtask

   task automatic test_lock_release();
      int len;
      reg_write(`PHY_TEST_RX_LOG_CTRL, 32'h1 << `PHY_TEST_RX_LOG_CTRL_RESET_POS);
      // First errored packet only releases the lock
      send_packet(5, next_random(2), 1'b1);
      read_expect("status after skipped packet", `PHY_TEST_RX_LOG_STATUS, 32'h0);
      len = 6 + next_random(2);
      send_packet(len, next_random(4) % len, 1'b1);
      read_expect("status after capture", `PHY_TEST_RX_LOG_STATUS, status_word(len, 1'b1));
      check_log_readout(len);
      finish_test("lock_release");
   endtask

   task automatic test_restart();
      // Leave a packet half done so restart has state to clear
      send_packet(3, -1, 1'b0);
      reg_write(`PHY_TEST_CTRL, 32'h1);
      read_expect("packet count", `PHY_TEST_PKT_COUNT, 32'd0);
      read_expect("error count", `PHY_TEST_ERR_COUNT, 32'd0);
      read_expect("log status", `PHY_TEST_RX_LOG_STATUS, 32'h0);
      send_packet(7, -1, 1'b1);
      read_expect("packet count after restart", `PHY_TEST_PKT_COUNT, 32'd1);
      read_expect("error count after restart", `PHY_TEST_ERR_COUNT, 32'd0);
      finish_test("restart");
   endtask

   // ==========================================================
   // Test sequence
   // ==========================================================
   initial begin
      int cap_len;
      reset       = 1'b1;
      rx_valid    = 1'b0;
      rx_data     = '0;
      rx_last     = 1'b0;
      reg_req     = 1'b0;
      reg_rd_wr_l = 1'b1;
      reg_addr    = '0;
      reg_wr_data = '0;
      repeat (2) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;

      test_register_access();
      test_clean_packets();
      test_error_capture(cap_len);
      test_lock_hold(cap_len);
      test_lock_release();
      test_restart();

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end
      else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
